// File: design/ice_pkg.sv
package ice_pkg;

    // record codes, first byte of each record
    localparam logic [7:0] code_mbus_rx = 8'h62;
    localparam logic [7:0] code_status  = 8'h73;

    // framer store for one record
    localparam int msg_depth = 64;
    localparam int msg_ptr_w = 6;

    // byte position that gets the record length
    localparam int length_slot = 2;

    // one byte on the stream from a source through the arbiter to the framer
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } buffer_byte_t;

endpackage

// File: design/mbus_rx_driver.sv
`timescale 1ns/1ps

module mbus_rx_driver import ice_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  logic [31:0]  mbus_rx_addr,
    input  logic [31:0]  mbus_rx_data,
    input  logic         mbus_rx_req,
    input  logic         mbus_rx_broadcast,
    input  logic         mbus_rx_fail,
    input  logic         mbus_rx_pend,
    input  logic [1:0]   mbus_rx_control_bits,
    output logic         mbus_rx_ack,

    output logic         buffer_request,
    input  logic         buffer_grant,
    output buffer_byte_t rx_byte,

    input  logic [7:0]   event_id,
    output logic         event_inc
);

    typedef enum logic [4:0] {
        st_idle,
        st_code,
        st_eid,
        st_length,
        st_addr0,
        st_addr1,
        st_addr2,
        st_addr3,
        st_data0,
        st_data1,
        st_data2,
        st_data3,
        st_pend,
        st_pend_ack,
        st_pend_wait,
        st_ctrl,
        st_end_ack
    } rx_state_t;

    rx_state_t state;
    rx_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next     = state;
        buffer_request = 1'b1; // held through every record state
        rx_byte        = '0;
        event_inc      = 1'b0;
        mbus_rx_ack    = 1'b0;

        case (state)
            st_idle: begin
                buffer_request = 1'b0;
                if (mbus_rx_fail) begin
                    state_next = st_end_ack; // nothing to record, just ack
                end else if (mbus_rx_req) begin
                    state_next = st_code;
                end
            end
            st_code: begin
                // code byte counts as written once the buffer is ours
                rx_byte.valid = buffer_grant;
                rx_byte.data  = code_mbus_rx;
                if (buffer_grant) begin
                    state_next = st_eid;
                end
            end
            st_eid: begin
                rx_byte   = '{valid: 1'b1, data: event_id};
                event_inc = 1'b1;
                state_next = st_length;
            end
            st_length: begin
                rx_byte    = '{valid: 1'b1, data: 8'h00}; // framer fills this in
                state_next = st_addr0;
            end
            st_addr0: begin
                rx_byte    = '{valid: 1'b1, data: mbus_rx_addr[31:24]};
                state_next = st_addr1;
            end
            st_addr1: begin
                rx_byte    = '{valid: 1'b1, data: mbus_rx_addr[23:16]};
                state_next = st_addr2;
            end
            st_addr2: begin
                rx_byte    = '{valid: 1'b1, data: mbus_rx_addr[15:8]};
                state_next = st_addr3;
            end
            st_addr3: begin
                rx_byte    = '{valid: 1'b1, data: mbus_rx_addr[7:0]};
                state_next = st_data0;
            end
            st_data0: begin
                rx_byte    = '{valid: 1'b1, data: mbus_rx_data[31:24]};
                state_next = st_data1;
            end
            st_data1: begin
                rx_byte    = '{valid: 1'b1, data: mbus_rx_data[23:16]};
                state_next = st_data2;
            end
            st_data2: begin
                rx_byte    = '{valid: 1'b1, data: mbus_rx_data[15:8]};
                state_next = st_data3;
            end
            st_data3: begin
                rx_byte    = '{valid: 1'b1, data: mbus_rx_data[7:0]};
                state_next = st_pend;
            end
            st_pend: begin
                state_next = mbus_rx_pend ? st_pend_ack : st_ctrl;
            end
            st_pend_ack: begin
                mbus_rx_ack = 1'b1;
                if (!mbus_rx_req) begin
                    state_next = st_pend_wait;
                end
            end
            st_pend_wait: begin
                // keep the buffer until the next word shows up
                if (mbus_rx_req) begin
                    state_next = st_data0;
                end
            end
            st_ctrl: begin
                rx_byte.valid = 1'b1;
                rx_byte.data  = {5'b00000, mbus_rx_broadcast, mbus_rx_control_bits};
                state_next    = st_end_ack;
            end
            st_end_ack: begin
                buffer_request = 1'b0;
                mbus_rx_ack    = 1'b1;
                // bus side must release both req and fail
                if (!mbus_rx_req && !mbus_rx_fail) begin
                    state_next = st_idle;
                end
            end
            default: begin
                buffer_request = 1'b0;
                state_next     = st_idle;
            end
        endcase
    end

endmodule

// File: design/status_event_source.sv
`timescale 1ns/1ps

module status_event_source import ice_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         status_pulse,
    input  logic [7:0]   status_code,
    output logic         buffer_request,
    input  logic         buffer_grant,
    output buffer_byte_t status_byte,
    input  logic [7:0]   event_id,
    output logic         event_inc
);

    typedef enum logic [2:0] {
        st_idle,
        st_code,
        st_eid,
        st_length,
        st_data
    } status_state_t;

    status_state_t state;
    status_state_t state_next;
    logic [7:0]    held_code;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // pulses outside idle are dropped
    always_ff @(posedge clk) begin
        if (state == st_idle && status_pulse) begin
            held_code <= status_code;
        end
    end

    always_comb begin
        state_next     = state;
        buffer_request = 1'b1;
        status_byte    = '0;
        event_inc      = 1'b0;

        case (state)
            st_idle: begin
                buffer_request = 1'b0;
                if (status_pulse) begin
                    state_next = st_code;
                end
            end
            st_code: begin
                status_byte.valid = buffer_grant;
                status_byte.data  = code_status;
                if (buffer_grant) begin
                    state_next = st_eid;
                end
            end
            st_eid: begin
                status_byte = '{valid: 1'b1, data: event_id};
                event_inc   = 1'b1;
                state_next  = st_length;
            end
            st_length: begin
                status_byte = '{valid: 1'b1, data: 8'h00};
                state_next  = st_data;
            end
            st_data: begin
                status_byte = '{valid: 1'b1, data: held_code};
                state_next  = st_idle; // request drops on the next cycle
            end
            default: begin
                buffer_request = 1'b0;
                state_next     = st_idle;
            end
        endcase
    end

endmodule

// File: design/buffer_arbiter.sv
`timescale 1ns/1ps

module buffer_arbiter import ice_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         rx_request,
    output logic         rx_grant,
    input  buffer_byte_t rx_byte,
    input  logic         st_request,
    output logic         st_grant,
    input  buffer_byte_t st_byte,
    input  logic         rx_inc,
    input  logic         st_inc,
    output logic [7:0]   event_id,
    input  logic         framer_busy,
    output buffer_byte_t buf_byte,
    output logic         buf_end
);

    typedef enum logic [1:0] {
        own_none,
        own_rx,
        own_st
    } owner_t;

    owner_t owner;
    owner_t owner_next;

    always_comb begin
        owner_next = owner;
        case (owner)
            own_none: begin
                // receive side wins a tie
                if (!framer_busy) begin
                    if (rx_request) begin
                        owner_next = own_rx;
                    end else if (st_request) begin
                        owner_next = own_st;
                    end
                end
            end
            own_rx:  if (!rx_request) owner_next = own_none;
            own_st:  if (!st_request) owner_next = own_none;
            default: owner_next = own_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            owner    <= own_none;
            event_id <= 8'h00;
        end else begin
            owner <= owner_next;
            if (rx_inc || st_inc) begin
                event_id <= event_id + 8'd1;
            end
        end
    end

    assign rx_grant = (owner == own_rx);
    assign st_grant = (owner == own_st);

    assign buf_byte = rx_grant ? rx_byte : (st_grant ? st_byte : '0);
    assign buf_end  = (rx_grant && !rx_request) || (st_grant && !st_request); // owner let go

endmodule

// File: design/message_framer.sv
`timescale 1ns/1ps

module message_framer import ice_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  buffer_byte_t buf_byte,
    input  logic         buf_end,
    output logic         busy,
    output buffer_byte_t host_byte
);

    logic [7:0]           store [msg_depth];
    logic [msg_ptr_w-1:0] wr_ptr;
    logic [msg_ptr_w-1:0] rd_ptr;
    logic [msg_ptr_w:0]   count; // saturates at msg_depth
    logic                 wr_en;
    logic                 last_byte;
    logic [7:0]           length_byte;

    assign wr_en       = buf_byte.valid && !busy && (count < msg_depth);
    assign last_byte   = ({1'b0, rd_ptr} == count - 1'b1);
    assign length_byte = {{(7 - msg_ptr_w){1'b0}}, count};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            store[wr_ptr] <= buf_byte.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            busy   <= 1'b0;
        end else if (busy) begin
            rd_ptr <= rd_ptr + 1'b1;
            if (last_byte) begin
                // record out, ready for the next one
                busy   <= 1'b0;
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                count  <= count + 1'b1;
            end
            if (buf_end && count != '0) begin
                busy   <= 1'b1;
                rd_ptr <= '0;
            end
        end
    end

    // replay, with the length slot patched on the way out
    always_comb begin
        host_byte.valid = busy;
        if (rd_ptr == msg_ptr_w'(length_slot)) begin
            host_byte.data = length_byte;
        end else begin
            host_byte.data = store[rd_ptr];
        end
    end

endmodule

// File: design/ice_rx_top.sv
`timescale 1ns/1ps

module ice_rx_top import ice_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  logic [31:0]  mbus_rx_addr,
    input  logic [31:0]  mbus_rx_data,
    input  logic         mbus_rx_req,
    input  logic         mbus_rx_broadcast,
    input  logic         mbus_rx_fail,
    input  logic         mbus_rx_pend,
    input  logic [1:0]   mbus_rx_control_bits,
    output logic         mbus_rx_ack,

    input  logic         status_pulse,
    input  logic [7:0]   status_code,

    output buffer_byte_t host_byte
);

    logic         rx_request;
    logic         rx_grant;
    logic         rx_inc;
    buffer_byte_t rx_byte;
    logic         st_request;
    logic         st_grant;
    logic         st_inc;
    buffer_byte_t st_byte;
    logic [7:0]   event_id;
    logic         framer_busy;
    buffer_byte_t buf_byte;
    logic         buf_end;

    mbus_rx_driver i_rx_driver (
        .clk                  (clk),
        .reset                (reset),
        .mbus_rx_addr         (mbus_rx_addr),
        .mbus_rx_data         (mbus_rx_data),
        .mbus_rx_req          (mbus_rx_req),
        .mbus_rx_broadcast    (mbus_rx_broadcast),
        .mbus_rx_fail         (mbus_rx_fail),
        .mbus_rx_pend         (mbus_rx_pend),
        .mbus_rx_control_bits (mbus_rx_control_bits),
        .mbus_rx_ack          (mbus_rx_ack),
        .buffer_request       (rx_request),
        .buffer_grant         (rx_grant),
        .rx_byte              (rx_byte),
        .event_id             (event_id),
        .event_inc            (rx_inc)
    );

    status_event_source i_status_source (
        .clk            (clk),
        .reset          (reset),
        .status_pulse   (status_pulse),
        .status_code    (status_code),
        .buffer_request (st_request),
        .buffer_grant   (st_grant),
        .status_byte    (st_byte),
        .event_id       (event_id),
        .event_inc      (st_inc)
    );

    buffer_arbiter i_arbiter (
        .clk         (clk),
        .reset       (reset),
        .rx_request  (rx_request),
        .rx_grant    (rx_grant),
        .rx_byte     (rx_byte),
        .st_request  (st_request),
        .st_grant    (st_grant),
        .st_byte     (st_byte),
        .rx_inc      (rx_inc),
        .st_inc      (st_inc),
        .event_id    (event_id),
        .framer_busy (framer_busy),
        .buf_byte    (buf_byte),
        .buf_end     (buf_end)
    );

    message_framer i_framer (
        .clk       (clk),
        .reset     (reset),
        .buf_byte  (buf_byte),
        .buf_end   (buf_end),
        .busy      (framer_busy),
        .host_byte (host_byte)
    );

endmodule

// File: test/tb_ice_rx.sv
`timescale 1ns/1ps

module tb_ice_rx import ice_pkg::*; ();

    localparam int reset_cycles  = 16;
    localparam int rx_cycles     = 40; // one receive incl. replay to host
    localparam int status_cycles = 20;
    localparam int quiet_cycles  = 20;
    localparam int random_count  = 20;
    localparam int test_cycles   = reset_cycles + (6 + 2 * random_count) * rx_cycles
                                   + 2 * status_cycles + 2 * quiet_cycles;
    localparam int watchdog_cycles = 4 * test_cycles;
    localparam int ack_limit     = 60;
    localparam int record_limit  = 100;

    logic         clk;
    logic         reset;
    logic [31:0]  mbus_rx_addr;
    logic [31:0]  mbus_rx_data;
    logic         mbus_rx_req;
    logic         mbus_rx_broadcast;
    logic         mbus_rx_fail;
    logic         mbus_rx_pend;
    logic [1:0]   mbus_rx_control_bits;
    logic         mbus_rx_ack;
    logic         status_pulse;
    logic [7:0]   status_code;
    buffer_byte_t host_byte;

    // expected host bytes, with the test each one belongs to
    logic [7:0]   exp_data[$];
    string        exp_test[$];
    logic [7:0]   next_eid;

    ice_rx_top i_dut (
        .clk                  (clk),
        .reset                (reset),
        .mbus_rx_addr         (mbus_rx_addr),
        .mbus_rx_data         (mbus_rx_data),
        .mbus_rx_req          (mbus_rx_req),
        .mbus_rx_broadcast    (mbus_rx_broadcast),
        .mbus_rx_fail         (mbus_rx_fail),
        .mbus_rx_pend         (mbus_rx_pend),
        .mbus_rx_control_bits (mbus_rx_control_bits),
        .mbus_rx_ack          (mbus_rx_ack),
        .status_pulse         (status_pulse),
        .status_code          (status_code),
        .host_byte            (host_byte)
    );

    always #10 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic void push_byte(input string name, input logic [7:0] value);
        exp_data.push_back(value);
        exp_test.push_back(name);
    endfunction

    // code, eid, length, addr msb first, data words, then bcast above ctrl
    function automatic void expect_rx_record(input string name, input logic [31:0] addr,
                                             input logic [31:0] w0, input logic [31:0] w1,
                                             input int nwords, input logic bcast,
                                             input logic [1:0] ctrl);
        int         len;
        logic [31:0] word;
        len = 8 + 4 * nwords;
        push_byte(name, code_mbus_rx);
        push_byte(name, next_eid);
        push_byte(name, 8'(len));
        for (int i = 3; i >= 0; i--) begin
            push_byte(name, addr[8*i +: 8]);
        end
        for (int w = 0; w < nwords; w++) begin
            word = (w == 0) ? w0 : w1;
            for (int i = 3; i >= 0; i--) begin
                push_byte(name, word[8*i +: 8]);
            end
        end
        push_byte(name, {5'b00000, bcast, ctrl});
        next_eid = next_eid + 8'd1;
    endfunction

    function automatic void expect_status_record(input string name, input logic [7:0] code);
        push_byte(name, code_status);
        push_byte(name, next_eid);
        push_byte(name, 8'd4);
        push_byte(name, code);
        next_eid = next_eid + 8'd1;
    endfunction

    task automatic wait_for_ack(input logic level, input string name);
        int n;
        n = 0;
        while (mbus_rx_ack !== level && n < ack_limit) begin
            @(negedge clk);
            n++;
        end
        assert (mbus_rx_ack === level) else begin
            stop_on_error($sformatf("test %s: mbus_rx_ack did not go to %0d within %0d cycles",
                                    name, level, ack_limit));
        end
    endtask

    task automatic wait_records_done(input string name);
        int n;
        n = 0;
        while (exp_data.size() != 0 && n < record_limit) begin
            @(negedge clk);
            n++;
        end
        assert (exp_data.size() == 0) else begin
            stop_on_error($sformatf("test %s: %0d expected bytes never reached the host",
                                    name, exp_data.size()));
        end
    endtask

    // one receive of one or two words, optionally with a status pulse in the same cycle
    task automatic run_receive(input string name, input logic [31:0] addr,
                               input logic [31:0] w0, input logic [31:0] w1,
                               input int nwords, input logic bcast, input logic [1:0] ctrl,
                               input logic with_status, input logic [7:0] code);
        expect_rx_record(name, addr, w0, w1, nwords, bcast, ctrl);
        if (with_status) begin
            expect_status_record(name, code);
        end
        @(negedge clk);
        mbus_rx_addr         = addr;
        mbus_rx_data         = w0;
        mbus_rx_broadcast    = bcast;
        mbus_rx_control_bits = ctrl;
        mbus_rx_pend         = (nwords > 1);
        mbus_rx_req          = 1'b1;
        status_pulse         = with_status;
        status_code          = code;
        @(negedge clk);
        status_pulse = 1'b0;
        wait_for_ack(1'b1, name);
        if (nwords > 1) begin
            mbus_rx_req  = 1'b0; // release the pend ack
            mbus_rx_pend = 1'b0;
            wait_for_ack(1'b0, name);
            mbus_rx_data = w1;
            mbus_rx_req  = 1'b1;
            wait_for_ack(1'b1, name);
        end
        mbus_rx_req = 1'b0;
        wait_for_ack(1'b0, name);
    endtask

    task automatic run_fail(input string name);
        @(negedge clk);
        mbus_rx_fail = 1'b1;
        mbus_rx_req  = 1'b1;
        wait_for_ack(1'b1, name);
        mbus_rx_fail = 1'b0;
        mbus_rx_req  = 1'b0;
        wait_for_ack(1'b0, name);
        repeat (quiet_cycles) @(negedge clk); // any host byte here is unexpected
    endtask

    task automatic run_status(input string name, input logic [7:0] code);
        expect_status_record(name, code);
        @(negedge clk);
        status_pulse = 1'b1;
        status_code  = code;
        @(negedge clk);
        status_pulse = 1'b0;
        wait_records_done(name);
    endtask

    always @(posedge clk) begin : compare
        logic [7:0] exp_byte;
        string      exp_name;
        if (!reset && host_byte.valid) begin
            if (exp_data.size() == 0) begin
                stop_on_error("host sent a byte while no record was expected");
            end else begin
                exp_byte = exp_data.pop_front();
                exp_name = exp_test.pop_front();
                assert (host_byte.data === exp_byte) else begin
                    stop_on_error($sformatf("error: test %s expected 0x%02h actual 0x%02h",
                                            exp_name, exp_byte, host_byte.data));
                end
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        stop_on_error($sformatf("timeout: run did not finish within %0d cycles",
                                watchdog_cycles));
    end

    initial begin : main
        int          kind;
        logic [31:0] r_addr;
        logic [31:0] r_w0;
        logic [31:0] r_w1;
        logic [7:0]  r_code;
        clk                  = 1'b0;
        reset                = 1'b1;
        mbus_rx_addr         = '0;
        mbus_rx_data         = '0;
        mbus_rx_req          = 1'b0;
        mbus_rx_broadcast    = 1'b0;
        mbus_rx_fail         = 1'b0;
        mbus_rx_pend         = 1'b0;
        mbus_rx_control_bits = 2'b00;
        status_pulse         = 1'b0;
        status_code          = 8'h00;
        next_eid             = 8'h00;
        void'($urandom(99450));

        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        assert (mbus_rx_ack === 1'b0 && host_byte.valid === 1'b0) else begin
            stop_on_error("ack or host valid is not low after reset");
        end

        run_receive("single_word", 32'h1234_5678, 32'hdead_beef, '0, 1, 1'b0, 2'b01, 1'b0, '0);
        run_receive("single_word", 32'ha0b1_c2d3, 32'h0011_2233, '0, 1, 1'b1, 2'b10, 1'b0, '0);
        wait_records_done("single_word");

        run_receive("pend_two_words", 32'h0000_00f1, 32'h1111_2222, 32'h3333_4444, 2,
                    1'b0, 2'b11, 1'b0, '0);
        wait_records_done("pend_two_words");

        run_fail("rx_fail");

        run_status("status", 8'h5a);

        run_receive("same_cycle", 32'h7654_3210, 32'hcafe_f00d, '0, 1, 1'b1, 2'b00,
                    1'b1, 8'hc3);
        wait_records_done("same_cycle");

        for (int k = 0; k < random_count; k++) begin
            kind   = $urandom_range(0, 2);
            r_addr = $urandom();
            r_w0   = $urandom();
            r_w1   = $urandom();
            r_code = 8'($urandom_range(0, 255));
            case (kind)
                0: run_receive("random_rx", r_addr, r_w0, r_w1, 1, 1'($urandom_range(0, 1)),
                               2'($urandom_range(0, 3)), 1'b0, '0);
                1: run_receive("random_pend", r_addr, r_w0, r_w1, 2, 1'($urandom_range(0, 1)),
                               2'($urandom_range(0, 3)), 1'b0, '0);
                default: run_status("random_status", r_code);
            endcase
        end
        wait_records_done("random");

        repeat (5) @(negedge clk); // stray host bytes would still be caught here
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: files.f
design/ice_pkg.sv
design/mbus_rx_driver.sv
design/status_event_source.sv
design/buffer_arbiter.sv
design/message_framer.sv
design/ice_rx_top.sv
test/tb_ice_rx.sv
